/* common/fetch_pkg.sv */
package fetch_pkg;

	// ****************************************
	// basic fetch types
	// ****************************************

	// byte address at full rv64 width
	typedef logic [63:0] addr_t;

	// one 32-bit instruction word
	typedef logic [31:0] inst_t;

	// boot address loaded by reset
	localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

	// opcodes the predecoder looks for
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// predecode outcome
	typedef enum logic [1:0] {
		none,
		branch_taken,
		jump
	} pred_kind_t;

	// ****************************************
	// stage interfaces
	// ****************************************

	// 97-bit bundle handed to decode
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  pred_taken;
	} fetch_bundle_t;

	// redirect from execute
	// valid stays high for a single cycle
	typedef struct packed {
		logic  valid;
		addr_t target;
	} redirect_t;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

	// ****************************************
	// icache geometry
	// ****************************************

	// four words per line, 16 bytes
	localparam int WORDS_PER_LINE = 4;
	localparam int NUM_LINES      = 16;

	// address split: tag | index | offset
	localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE * 4);
	localparam int INDEX_BITS  = $clog2(NUM_LINES);
	localparam int TAG_BITS    = 64 - INDEX_BITS - OFFSET_BITS;

	// one full line of data
	typedef logic [WORDS_PER_LINE*32-1:0] line_t;

	// ****************************************
	// refill handshake payloads
	// ****************************************

	// line-aligned address of the missing line
	typedef struct packed {
		fetch_pkg::addr_t line_addr;
	} refill_req_t;

	// whole line returned with the ack
	typedef struct packed {
		line_t data;
	} refill_resp_t;

endpackage

/* ifu/branch_predecode.sv */
module branch_predecode (
	input  fetch_pkg::addr_t      pc,
	input  fetch_pkg::inst_t      inst,
	output fetch_pkg::pred_kind_t kind,
	output fetch_pkg::addr_t      next_pc
);
	import fetch_pkg::*;

	logic  is_jal;
	logic  is_branch;
	addr_t imm_b;
	addr_t imm_j;

	// jal has no funct3
	assign is_jal = (inst[6:0] == OPC_JAL);

	// the six conditional branches
	// funct3 010 and 011 are reserved
	always_comb begin
		is_branch = 1'b0;
		if (inst[6:0] == OPC_BRANCH) begin
			case (inst[14:12])
				3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111: is_branch = 1'b1;
				default: is_branch = 1'b0;
			endcase
		end
	end

	// b-type immediate, sign from bit 31
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// j-type immediate
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// static rule: backward branch taken
	// forward branch falls through
	always_comb begin
		if (is_jal) begin
			kind = jump;
		end else if (is_branch && inst[31]) begin
			kind = branch_taken;
		end else begin
			kind = none;
		end
	end

	// predicted successor
	always_comb begin
		case (kind)
			jump:         next_pc = pc + imm_j;
			branch_taken: next_pc = pc + imm_b;
			default:      next_pc = pc + 64'd4;
		endcase
	end

endmodule

/* ifu/ifu.sv */
module ifu (
	input  logic                     clk,
	input  logic                     rst,
	input  fetch_pkg::redirect_t     redirect,
	output logic                     fetch_valid,
	input  logic                     fetch_ready,
	output fetch_pkg::fetch_bundle_t fetch_out,
	output fetch_pkg::addr_t         lookup_pc,
	input  logic                     hit,
	input  fetch_pkg::inst_t         hit_inst
);
	import fetch_pkg::*;

	addr_t      pc_q;
	addr_t      next_pc;
	pred_kind_t kind;
	inst_t      cur_inst;
	inst_t      hold_inst;
	logic       hold_valid;
	logic       accept;

	// ****************************************
	// lookup and offer
	// ****************************************

	assign lookup_pc = pc_q;

	// held word wins over the live cache output
	// a refill can replace the line while decode stalls
	assign cur_inst = hold_valid ? hold_inst : hit_inst;

	branch_predecode u_predecode (
		.pc      (pc_q),
		.inst    (cur_inst),
		.kind    (kind),
		.next_pc (next_pc)
	);

	// nothing offered in the redirect cycle
	assign fetch_valid = (hit || hold_valid) && !redirect.valid;
	assign accept      = fetch_valid && fetch_ready;

	always_comb begin
		fetch_out.pc         = pc_q;
		fetch_out.inst       = cur_inst;
		fetch_out.pred_taken = (kind != none);
	end

	// ****************************************
	// program counter
	// ****************************************

	// priority: redirect, accept, hold
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= RESET_PC;
		end else if (redirect.valid) begin
			pc_q <= redirect.target;
		end else if (accept) begin
			pc_q <= next_pc;
		end
	end

	// stall capture
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else if (redirect.valid || accept) begin
			hold_valid <= 1'b0;
		end else if (fetch_valid) begin
			hold_valid <= 1'b1;
		end
	end

	// first stalled cycle latches the word
	always_ff @(posedge clk) begin
		if (fetch_valid && !fetch_ready && !hold_valid) begin
			hold_inst <= hit_inst;
		end
	end

endmodule

/* icache/icache.sv */
module icache (
	input  logic                  clk,
	input  logic                  rst,
	input  fetch_pkg::addr_t      lookup_pc,
	output logic                  hit,
	output fetch_pkg::inst_t      hit_inst,
	output logic                  mem_req,
	output mem_pkg::refill_req_t  mem_req_data,
	input  logic                  mem_ack,
	input  mem_pkg::refill_resp_t mem_resp
);
	import fetch_pkg::*;
	import mem_pkg::*;

	// refill handshake phases
	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release
	} refill_state_t;

	logic                   valid_q [NUM_LINES];
	logic [TAG_BITS-1:0]    tag_q   [NUM_LINES];
	line_t                  data_q  [NUM_LINES];

	logic [INDEX_BITS-1:0]  lookup_index;
	logic [TAG_BITS-1:0]    lookup_tag;
	logic [OFFSET_BITS-3:0] lookup_word;
	line_t                  lookup_line;

	refill_state_t          state_q;
	addr_t                  fill_addr_q;
	logic [INDEX_BITS-1:0]  fill_index;
	logic [TAG_BITS-1:0]    fill_tag;
	logic                   start_miss;
	logic                   fill_write;

	// ****************************************
	// lookup
	// ****************************************

	assign lookup_index = lookup_pc[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag   = lookup_pc[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	// bits [1:0] are always zero for rv64 without compressed
	assign lookup_word  = lookup_pc[OFFSET_BITS-1:2];
	assign lookup_line  = data_q[lookup_index];

	// combinational from the registered arrays
	assign hit      = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
	assign hit_inst = lookup_line[32*lookup_word +: 32];

	// ****************************************
	// refill fsm
	// ****************************************

	// new request only once the previous ack is gone
	assign start_miss = (state_q == st_idle) && !hit && !mem_ack;

	// line lands on the edge that samples ack
	assign fill_write = (state_q == st_request) && mem_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (start_miss) begin
						state_q <= st_request;
					end
				end
				st_request: begin
					if (mem_ack) begin
						state_q <= st_release;
					end
				end
				st_release: begin
					// wait for memory to drop ack
					if (!mem_ack) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// line address frozen for the whole request
	always_ff @(posedge clk) begin
		if (start_miss) begin
			fill_addr_q <= {lookup_pc[63:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		end
	end

	assign fill_index = fill_addr_q[OFFSET_BITS +: INDEX_BITS];
	assign fill_tag   = fill_addr_q[OFFSET_BITS+INDEX_BITS +: TAG_BITS];

	assign mem_req                = (state_q == st_request);
	assign mem_req_data.line_addr = fill_addr_q;

	// ****************************************
	// arrays
	// ****************************************

	// valid bits cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else if (fill_write) begin
			valid_q[fill_index] <= 1'b1;
		end
	end

	// tag and data follow the valid bit
	always_ff @(posedge clk) begin
		if (fill_write) begin
			tag_q[fill_index]  <= fill_tag;
			data_q[fill_index] <= mem_resp.data;
		end
	end

endmodule

/* source/fetch_top.sv */
module fetch_top (
	input  logic                     clk,
	input  logic                     rst,
	input  fetch_pkg::redirect_t     redirect,
	output logic                     fetch_valid,
	input  logic                     fetch_ready,
	output fetch_pkg::fetch_bundle_t fetch_out,
	output logic                     mem_req,
	output mem_pkg::refill_req_t     mem_req_data,
	input  logic                     mem_ack,
	input  mem_pkg::refill_resp_t    mem_resp
);
	import fetch_pkg::*;

	// ifu to icache lookup path
	addr_t lookup_pc;
	logic  hit;
	inst_t hit_inst;

	// ****************************************
	// fetch unit
	// ****************************************

	ifu u_ifu (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.fetch_out   (fetch_out),
		.lookup_pc   (lookup_pc),
		.hit         (hit),
		.hit_inst    (hit_inst)
	);

	// ****************************************
	// instruction cache
	// ****************************************

	icache u_icache (
		.clk          (clk),
		.rst          (rst),
		.lookup_pc    (lookup_pc),
		.hit          (hit),
		.hit_inst     (hit_inst),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.mem_ack      (mem_ack),
		.mem_resp     (mem_resp)
	);

endmodule

/* sim/fetch_assert.sv */
module fetch_assert (
	input logic                 clk,
	input logic                 rst,
	input logic                 mem_req,
	input mem_pkg::refill_req_t mem_req_data,
	input logic                 mem_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions so far
	int failures = 0;

	// ****************************************
	// refill handshake rules
	// ****************************************

	// req only drops once ack was seen
	assert property (@(posedge clk) disable iff (rst)
		$fell(mem_req) |-> $past(mem_ack))
		else begin
			failures++;
			$error("mem_req fell without mem_ack");
		end

	// new req only with ack low
	assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !$past(mem_ack))
		else begin
			failures++;
			$error("mem_req rose while mem_ack high");
		end

	// line address frozen during the request
	assert property (@(posedge clk) disable iff (rst)
		(mem_req && $past(mem_req)) |-> (mem_req_data == $past(mem_req_data)))
		else begin
			failures++;
			$error("mem_req_data changed while mem_req high");
		end

endmodule

bind icache fetch_assert u_fetch_assert (
	.clk          (clk),
	.rst          (rst),
	.mem_req      (mem_req),
	.mem_req_data (mem_req_data),
	.mem_ack      (mem_ack)
);

/* sim/fetch_tb.sv */
module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;
	import mem_pkg::*;

	localparam int TIMEOUT = 2000;

	logic          clk;
	logic          rst;
	redirect_t     redirect;
	logic          fetch_valid;
	logic          fetch_ready;
	fetch_bundle_t fetch_out;
	logic          mem_req;
	refill_req_t   mem_req_data;
	logic          mem_ack;
	refill_resp_t  mem_resp;

	// sparse program image
	logic [31:0] mem_words [logic [63:0]];

	// expected stream, in transfer order
	int    exp_test [$];
	addr_t exp_pc [$];
	inst_t exp_inst [$];
	logic  exp_pred [$];

	// redirect schedule
	int    redir_at [$];
	addr_t redir_target [$];

	int    errors;
	int    tests_done;
	int    test_errors [1:5];
	string test_name [1:5];
	logic  mem_stuck;

	fetch_top dut0 (
		.clk          (clk),
		.rst          (rst),
		.redirect     (redirect),
		.fetch_valid  (fetch_valid),
		.fetch_ready  (fetch_ready),
		.fetch_out    (fetch_out),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.mem_ack      (mem_ack),
		.mem_resp     (mem_resp)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// ****************************************
	// memory image helpers
	// ****************************************

	// words missing from the image
	// opcode forced to op-imm, never predicted
	function automatic inst_t fill_word(addr_t a);
		logic [31:0] f;
		f = a[31:0] ^ a[63:32];
		return {f[31:7] ^ {18'h0, f[6:0]}, 7'h13};
	endfunction

	function automatic inst_t word_at(addr_t a);
		if (mem_words.exists(a)) begin
			return mem_words[a];
		end
		return fill_word(a);
	endfunction

	// word 0 in the low bits
	function automatic line_t line_at(addr_t a);
		line_t l;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			l[32*w +: 32] = word_at(a + 64'(4 * w));
		end
		return l;
	endfunction

	task automatic load_stimulus();
		int    fd;
		int    n;
		int    t;
		int    pred;
		byte   kind;
		string text;
		addr_t a;
		addr_t b;
		fd = $fopen("sim/fetch_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/fetch_stimulus.txt");
			errors++;
			return;
		end
		while ($fgets(text, fd) > 0) begin
			n = $sscanf(text, "%c", kind);
			case (kind)
				"M": begin
					n = $sscanf(text, "%c %h %h", kind, a, b);
					mem_words[a] = b[31:0];
				end
				"R": begin
					n = $sscanf(text, "%c %d %h", kind, t, a);
					redir_at.push_back(t);
					redir_target.push_back(a);
				end
				"E": begin
					n = $sscanf(text, "%c %d %h %h %d", kind, t, a, b, pred);
					exp_test.push_back(t);
					exp_pc.push_back(a);
					exp_inst.push_back(b[31:0]);
					exp_pred.push_back(pred[0]);
				end
				// comments and blank lines
				default: ;
			endcase
		end
		$fclose(fd);
	endtask

	// ****************************************
	// checking and report
	// ****************************************

	task automatic note_error(int t);
		errors++;
		test_errors[t]++;
	endtask

	task automatic check_transfer(int i);
		if (fetch_out.pc !== exp_pc[i] || fetch_out.inst !== exp_inst[i]
				|| fetch_out.pred_taken !== exp_pred[i]) begin
			$display("ERROR at %0t: transfer %0d got pc %h inst %h pred %b",
				$time, i + 1, fetch_out.pc, fetch_out.inst, fetch_out.pred_taken);
			$display("ERROR at %0t: transfer %0d expected pc %h inst %h pred %b",
				$time, i + 1, exp_pc[i], exp_inst[i], exp_pred[i]);
			note_error(exp_test[i]);
		end
	endtask

	task automatic report_test(int t);
		tests_done++;
		if (test_errors[t] == 0) begin
			$display("test %0d %s: ok", t, test_name[t]);
		end else begin
			$display("test %0d %s: %0d mismatches", t, test_name[t], test_errors[t]);
		end
	endtask

	// ****************************************
	// four-phase memory model
	// ****************************************

	initial begin
		int phase;
		int delay;
		int hold;
		mem_ack   = 1'b0;
		mem_resp  = '0;
		mem_stuck = 1'b0;
		phase     = 0;
		delay     = 0;
		hold      = 0;
		forever begin
			@(negedge clk);
			if (rst) begin
				mem_ack = 1'b0;
				phase   = 0;
			end else if (phase == 0 && mem_req) begin
				// random ack delay, 0 to 5 cycles
				delay = $urandom % 6;
				phase = 1;
			end else if (phase == 2) begin
				// release phase, wait for req to drop
				if (!mem_req) begin
					mem_ack = 1'b0;
					phase   = 0;
				end else begin
					hold++;
					if (hold >= TIMEOUT) begin
						mem_stuck = 1'b1;
					end
				end
			end
			if (phase == 1) begin
				if (delay == 0) begin
					mem_resp.data = line_at(mem_req_data.line_addr);
					mem_ack       = 1'b1;
					hold          = 0;
					phase         = 2;
				end else begin
					delay--;
				end
			end
		end
	end

	// ****************************************
	// stimulus and stream checker
	// ****************************************

	initial begin
		int            seed_ret;
		int            done;
		int            idle;
		int            ri;
		int            cur;
		logic          stalled;
		logic          timed_out;
		fetch_bundle_t held;
		seed_ret    = $urandom(32'hc9f96abc);
		clk         = 1'b0;
		rst         = 1'b1;
		redirect    = '0;
		fetch_ready = 1'b0;
		errors      = 0;
		tests_done  = 0;
		for (int t = 1; t <= 5; t++) begin
			test_errors[t] = 0;
		end
		test_name[1] = "sequential fetch";
		test_name[2] = "static prediction";
		test_name[3] = "redirect";
		test_name[4] = "back-pressure";
		test_name[5] = "redirect during refill";
		load_stimulus();
		if (exp_pc.size() == 0) begin
			$display("stimulus file holds no expected transfers");
			errors++;
		end
		repeat (16) @(negedge clk);
		rst       = 1'b0;
		done      = 0;
		idle      = 0;
		ri        = 0;
		stalled   = 1'b0;
		timed_out = 1'b0;
		held      = '0;
		while (done < exp_pc.size() && !timed_out) begin
			@(negedge clk);
			cur = exp_test[done];
			// one-cycle redirect after the scheduled transfer
			redirect = '0;
			if (ri < redir_at.size() && redir_at[ri] == done) begin
				redirect.valid  = 1'b1;
				redirect.target = redir_target[ri];
				ri++;
			end
			// decode stalls from test 4 on
			fetch_ready = (cur >= 4) ? (($urandom % 4) != 0) : 1'b1;
			// let the combinational outputs settle
			#1;
			if (redirect.valid && fetch_valid) begin
				$display("ERROR at %0t: fetch_valid high in redirect cycle", $time);
				note_error(cur);
			end
			if (stalled && fetch_valid && fetch_out != held) begin
				$display("ERROR at %0t: fetch_out changed under stall, %h to %h",
					$time, held, fetch_out);
				note_error(cur);
			end
			stalled = fetch_valid && !fetch_ready;
			held    = fetch_out;
			// transfer takes place on the coming rising edge
			if (fetch_valid && fetch_ready) begin
				check_transfer(done);
				done++;
				idle = 0;
				if (done == exp_pc.size() || exp_test[done] != cur) begin
					report_test(cur);
				end
			end else begin
				idle++;
			end
			if (idle >= TIMEOUT) begin
				$display("timeout: no transfer within %0d cycles after transfer %0d",
					TIMEOUT, done);
				timed_out = 1'b1;
			end
			if (mem_stuck) begin
				$display("timeout: memory handshake did not complete");
				timed_out = 1'b1;
			end
		end
		if (timed_out) begin
			errors++;
		end
		if (dut0.u_icache.u_fetch_assert.failures != 0) begin
			$display("refill handshake assertions failed %0d times",
				dut0.u_icache.u_fetch_assert.failures);
			errors += dut0.u_icache.u_fetch_assert.failures;
		end
		$display("%0d tests finished, %0d of %0d transfers, %0d errors",
			tests_done, done, exp_pc.size(), errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim/fetch_stimulus.txt */
# M addr word (hex) | R n target, redirect after the nth transfer (n decimal, target hex)
# E test pc inst pred_taken, one line per transfer in order (test and pred decimal)
M 80000000 00100093
M 80000004 00200093
M 80000008 00300093
M 8000000c 00400093
M 80000010 00500093
M 80000014 00600093
M 80000018 00700093
M 8000001c 00800093
M 80000020 0200006f
M 80000040 00208463
M 80000044 00900093
M 80000048 fe209ce3
M 80000080 00a00093
M 80000084 00b00093
M 80000100 1000006f
M 80000200 bad00093
M 80000300 00c00093
M 80000304 00d00093
R 13 80000080
R 15 80000000
R 23 80000100
R 24 80000300
E 1 80000000 00100093 0
E 1 80000004 00200093 0
E 1 80000008 00300093 0
E 1 8000000c 00400093 0
E 1 80000010 00500093 0
E 1 80000014 00600093 0
E 1 80000018 00700093 0
E 1 8000001c 00800093 0
E 2 80000020 0200006f 1
E 2 80000040 00208463 0
E 2 80000044 00900093 0
E 2 80000048 fe209ce3 1
E 2 80000040 00208463 0
E 3 80000080 00a00093 0
E 3 80000084 00b00093 0
E 4 80000000 00100093 0
E 4 80000004 00200093 0
E 4 80000008 00300093 0
E 4 8000000c 00400093 0
E 4 80000010 00500093 0
E 4 80000014 00600093 0
E 4 80000018 00700093 0
E 4 8000001c 00800093 0
E 5 80000100 1000006f 1
E 5 80000300 00c00093 0
E 5 80000304 00d00093 0

/* verilog.f */
common/fetch_pkg.sv
common/mem_pkg.sv
ifu/branch_predecode.sv
ifu/ifu.sv
icache/icache.sv
source/fetch_top.sv
sim/fetch_assert.sv
sim/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

TOP := fetch_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
